/* tb/fpc_tests.txt */
# name op(0 cmp_lo,1 cmp_hi,2 min,3 max,4 abs,5 neg,6 sgnj) a b result flags
# a, b and result are {high, low} in hex; flags are {lt,eq,gt,unord,inv} in hex
cmp_lo_lt      0 400000003F800000 3F80000040000000 0000000000000000 10
cmp_hi_gt      1 400000003F800000 3F80000040000000 0000000000000000 04
cmp_lo_eq      0 0000000040400000 3F80000040400000 0000000000000000 08
cmp_lo_zero    0 0000000080000000 0000000000000000 0000000000000000 08
cmp_hi_neg     1 BF80000000000000 C000000000000000 0000000000000000 04
cmp_lo_negpos  0 00000000C0000000 000000003F000000 0000000000000000 10
cmp_lo_nan     0 000000007FC00000 000000003F800000 0000000000000000 03
cmp_hi_nan_b   1 3F80000000000000 FFC0012300000000 0000000000000000 03
cmp_lo_nan_hi  0 7F8000013F800000 3F8000003F800000 0000000000000000 08
cmp_hi_snan    1 7F80000100000000 7F80000100000000 0000000000000000 03
cmp_lo_inf     0 000000007F800000 000000007F7FFFFF 0000000000000000 04
cmp_hi_zero    1 0000000000000000 8000000000000000 0000000000000000 08
min_basic      2 400000003F800000 3F80000040000000 3F8000003F800000 10
max_basic      3 400000003F800000 3F80000040000000 4000000040000000 10
min_zero       2 0000000080000000 8000000000000000 8000000080000000 08
max_zero       3 0000000080000000 8000000000000000 0000000000000000 08
min_nan_a      2 3F8000007FC00000 40400000C0000000 3F800000C0000000 03
max_nan_b      3 BF8000003F000000 C0000000FFC00123 BF8000003F000000 03
min_two_nan    2 400000007F800001 40000000FFC00123 400000007FC00000 03
max_two_nan_hi 3 7F8000013F800000 FFC00123BF800000 7FC000003F800000 04
min_neg        2 C0000000BF800000 BF800000C0000000 C0000000C0000000 04
max_neg        3 C0000000BF800000 BF800000C0000000 BF800000BF800000 04
abs_basic      4 BF80000040000000 0000000000000000 3F80000040000000 00
abs_nan        4 FFC0012380000000 0000000000000000 7FC0012300000000 00
neg_basic      5 BF80000040000000 0000000000000000 3F800000C0000000 00
neg_zero       5 8000000000000000 0000000000000000 0000000080000000 00
neg_nan        5 7F800001FFC00000 0000000000000000 FF8000017FC00000 00
sgnj_basic     6 3F800000C0000000 800000003F000000 BF80000040000000 00
sgnj_same      6 BF80000040400000 C000000040000000 BF80000040400000 00
sgnj_nan       6 7FC00000BF800000 0000000080000000 7FC00000BF800000 00

/* sim.f */
rtl/fpc_pkg.sv
rtl/fpc_dispatch.sv
rtl/fpc_lane.sv
rtl/fpc_retire.sv
rtl/fpc_cluster.sv
tb/fpc_cluster_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
verilator --binary --timing --assert -f sim.f --top-module fpc_cluster_tb \
  -Mdir obj_dir -o fpc_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/fpc_sim > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log && echo "Simulation passed" || { echo "No result line"; exit 1; }

/* tb/fpc_cluster_tb.sv */
`timescale 1ns/1ns

module fpc_cluster_tb;
  import fpc_pkg::*;

  localparam int MAX_TESTS     = 64;
  localparam int TIMEOUT       = 200;  // Cycles per wait loop
  localparam int LATENCY       = 5;    // Accepting edge to out_valid
  localparam int MAX_IN_FLIGHT = 3;    // One operation per lane

  logic       clk;
  logic       arst_n;
  logic       in_valid;
  fpc_op_t    in_op;
  fpc_word_t  in_a;
  fpc_word_t  in_b;
  fpc_tag_t   in_tag;
  logic       in_ready;
  logic       out_valid;
  fpc_word_t  out_result;
  fpc_flags_t out_flags;
  fpc_tag_t   out_tag;
  logic       flags_clr;
  logic       flags_sticky;

  string      names [MAX_TESTS];
  logic [2:0] ops [MAX_TESTS];
  fpc_word_t  vec_a [MAX_TESTS];
  fpc_word_t  vec_b [MAX_TESTS];
  fpc_word_t  exp_res [MAX_TESTS];
  fpc_flags_t exp_flg [MAX_TESTS];
  int         n_tests;

  int         accept_cyc [2*MAX_TESTS];
  logic       got [2*MAX_TESTS];
  int         tag_to_issue [16];
  int         cycle;
  int         n_done;
  int         n_pass;
  int         errors;
  int         in_flight;
  int         max_in_flight;

  fpc_cluster uut (
    .clk(clk), .arst_n(arst_n),
    .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b), .in_tag(in_tag),
    .in_ready(in_ready),
    .out_valid(out_valid), .out_result(out_result), .out_flags(out_flags),
    .out_tag(out_tag), .flags_clr(flags_clr), .flags_sticky(flags_sticky)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // ====================================================================
  // Test file
  // ====================================================================
  task automatic load_tests();
    int    fd;
    int    cnt;
    int    op_i;
    string line;
    fd = $fopen("tb/fpc_tests.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open tb/fpc_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != 8'h23) begin  // Skip comment lines
          cnt = $sscanf(line, "%s %d %h %h %h %h", names[n_tests], op_i,
                        vec_a[n_tests], vec_b[n_tests], exp_res[n_tests], exp_flg[n_tests]);
          if (cnt == 6) begin
            ops[n_tests] = op_i[2:0];
            n_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ====================================================================
  // Result monitor, matched by tag
  // ====================================================================
  always @(posedge clk) begin
    if (arst_n && out_valid) begin : mon
      int   k;
      int   t;
      logic ok;
      k  = tag_to_issue[out_tag];
      ok = 1'b1;
      if (k < 0 || got[k]) begin
        $display("ERROR: unexpected result with tag %0d", out_tag);
        errors++;
      end else begin
        t      = k % n_tests;
        got[k] = 1'b1;
        assert (out_result == exp_res[t]) else begin
          $display("Fail %s: result expected %h, actual %h", names[t], exp_res[t], out_result);
          ok = 1'b0;
        end
        assert (out_flags == exp_flg[t]) else begin
          $display("Fail %s: flags expected %h, actual %h", names[t], exp_flg[t], out_flags);
          ok = 1'b0;
        end
        assert (cycle - accept_cyc[k] == LATENCY) else begin
          $display("Fail %s: latency expected %0d, actual %0d", names[t], LATENCY,
                   cycle - accept_cyc[k]);
          ok = 1'b0;
        end
        if (ok) n_pass++;
        n_done++;
        $display("%s issue %3d tag %2d: %s", names[t], k, out_tag, ok ? "ok" : "mismatch");
      end
    end
  end

  // Operations accepted and not yet returned
  always @(posedge clk) begin
    if (arst_n) begin
      in_flight = in_flight + int'(in_valid && in_ready) - int'(out_valid);
      if (in_flight > max_in_flight) max_in_flight = in_flight;
    end
  end

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    int   total;
    int   gap;
    int   w;
    logic stop;
    arst_n        = 1'b0;
    in_valid      = 1'b0;
    in_op         = OP_CMP_LO;
    in_a          = '0;
    in_b          = '0;
    in_tag        = '0;
    flags_clr     = 1'b0;
    cycle         = 0;
    n_done        = 0;
    n_pass        = 0;
    errors        = 0;
    n_tests       = 0;
    in_flight     = 0;
    max_in_flight = 0;
    stop          = 1'b0;
    for (int i = 0; i < 16; i++) tag_to_issue[i] = -1;
    for (int i = 0; i < 2*MAX_TESTS; i++) got[i] = 1'b0;
    void'($urandom(93));
    load_tests();
    total = 2 * n_tests;  // Random gaps first, then a burst with none

    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    assert (in_ready && !out_valid && !flags_sticky) else begin
      $display("Fail reset: {in_ready, out_valid, flags_sticky} expected 100, actual %b%b%b",
               in_ready, out_valid, flags_sticky);
      errors++;
    end

    for (int k = 0; k < total && !stop; k++) begin
      gap = (k < n_tests) ? int'($urandom % 3) : 0;
      if (gap > 0) begin
        in_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      in_valid <= 1'b1;
      in_op    <= fpc_op_t'(ops[k % n_tests]);
      in_a     <= vec_a[k % n_tests];
      in_b     <= vec_b[k % n_tests];
      in_tag   <= fpc_tag_t'(k);
      tag_to_issue[k % 16] = k;
      w = 0;
      do begin
        @(posedge clk);
        w++;
      end while (!in_ready && w < TIMEOUT);
      if (!in_ready) begin
        $display("ERROR: issue %0d was not accepted within %0d cycles", k, TIMEOUT);
        errors++;
        stop = 1'b1;
      end
      accept_cyc[k] = cycle;
    end
    in_valid <= 1'b0;

    w = 0;
    while (n_done < total && w < TIMEOUT) begin
      @(posedge clk);
      w++;
    end
    for (int k = 0; k < total; k++) begin
      if (!got[k]) begin
        $display("ERROR: no result for %s (issue %0d) within the timeout",
                 names[k % n_tests], k);
        errors++;
      end
    end

    // Burst without gaps fills every lane
    assert (max_in_flight == MAX_IN_FLIGHT) else begin
      $display("Fail burst: operations in flight expected %0d, actual %0d",
               MAX_IN_FLIGHT, max_in_flight);
      errors++;
    end

    // Sticky flag held, then cleared
    @(posedge clk);
    assert (flags_sticky) else begin
      $display("Fail sticky_set: flags_sticky expected 1, actual %b", flags_sticky);
      errors++;
    end
    flags_clr <= 1'b1;
    @(posedge clk);
    flags_clr <= 1'b0;
    @(posedge clk);
    assert (!flags_sticky) else begin
      $display("Fail sticky_clr: flags_sticky expected 0, actual %b", flags_sticky);
      errors++;
    end

    $display("Tests: %0d issued, %0d passed, %0d failed, %0d other errors",
             total, n_pass, total - n_pass, errors);
    if (errors == 0 && n_pass == total && total > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* rtl/fpc_cluster.sv */
`timescale 1ns/1ns

module fpc_cluster (
  input  logic                clk,
  input  logic                arst_n,
  // Issue port
  input  logic                in_valid,
  input  fpc_pkg::fpc_op_t    in_op,
  input  fpc_pkg::fpc_word_t  in_a,
  input  fpc_pkg::fpc_word_t  in_b,
  input  fpc_pkg::fpc_tag_t   in_tag,
  output logic                in_ready,
  // Result port
  output logic                out_valid,
  output fpc_pkg::fpc_word_t  out_result,
  output fpc_pkg::fpc_flags_t out_flags,
  output fpc_pkg::fpc_tag_t   out_tag,
  input  logic                flags_clr,
  output logic                flags_sticky
);
  import fpc_pkg::*;

  logic [NUM_LANES-1:0] lane_start;
  logic [NUM_LANES-1:0] lane_busy;
  logic [NUM_LANES-1:0] lane_done;
  fpc_op_t              lane_op;     // Shared payload to all lanes
  fpc_word_t            lane_a;
  fpc_word_t            lane_b;
  fpc_tag_t             lane_tag;
  fpc_word_t            lane_result [NUM_LANES];
  fpc_flags_t           lane_flags [NUM_LANES];
  fpc_tag_t             lane_res_tag [NUM_LANES];

  fpc_dispatch u_dispatch (
    .clk(clk), .arst_n(arst_n),
    .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b), .in_tag(in_tag),
    .in_ready(in_ready),
    .lane_busy(lane_busy), .lane_start(lane_start),
    .lane_op(lane_op), .lane_a(lane_a), .lane_b(lane_b), .lane_tag(lane_tag)
  );

  // ====================================================================
  // Lanes
  // ====================================================================
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    fpc_lane u_lane (
      .clk(clk), .arst_n(arst_n),
      .start(lane_start[i]), .op(lane_op), .a(lane_a), .b(lane_b), .tag(lane_tag),
      .busy(lane_busy[i]), .done(lane_done[i]),
      .result(lane_result[i]), .flags(lane_flags[i]), .res_tag(lane_res_tag[i])
    );
  end

  fpc_retire u_retire (
    .clk(clk), .arst_n(arst_n),
    .done(lane_done),
    .lane_result(lane_result), .lane_flags(lane_flags), .lane_tag(lane_res_tag),
    .flags_clr(flags_clr),
    .out_valid(out_valid), .out_result(out_result), .out_flags(out_flags),
    .out_tag(out_tag), .flags_sticky(flags_sticky)
  );

endmodule

/* rtl/fpc_retire.sv */
`timescale 1ns/1ns

module fpc_retire (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [fpc_pkg::NUM_LANES-1:0] done,
  input  fpc_pkg::fpc_word_t            lane_result [fpc_pkg::NUM_LANES],
  input  fpc_pkg::fpc_flags_t           lane_flags [fpc_pkg::NUM_LANES],
  input  fpc_pkg::fpc_tag_t             lane_tag [fpc_pkg::NUM_LANES],
  input  logic                          flags_clr,
  output logic                          out_valid,
  output fpc_pkg::fpc_word_t            out_result,
  output fpc_pkg::fpc_flags_t           out_flags,
  output fpc_pkg::fpc_tag_t             out_tag,
  output logic                          flags_sticky
);
  import fpc_pkg::*;

  lane_sel_t  sel;
  fpc_flags_t sel_flags;
  logic       any_done;
  logic       retire_inv;

  // Lowest index wins, scanned from the top down
  always_comb begin
    sel = '0;
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (done[i]) begin
        sel = lane_sel_t'(i);
      end
    end
  end

  assign any_done   = |done;
  assign sel_flags  = lane_flags[sel];
  assign retire_inv = any_done & sel_flags[FLAG_INV];

  // ====================================================================
  // Result port and sticky flag
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid    <= 1'b0;
      flags_sticky <= 1'b0;
    end else begin
      out_valid <= any_done;
      if (retire_inv) begin
        flags_sticky <= 1'b1;  // New invalid beats the clear
      end else if (flags_clr) begin
        flags_sticky <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (any_done) begin
      out_result <= lane_result[sel];
      out_flags  <= sel_flags;
      out_tag    <= lane_tag[sel];
    end
  end

endmodule

/* rtl/fpc_lane.sv */
`timescale 1ns/1ns

module fpc_lane (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                start,
  input  fpc_pkg::fpc_op_t    op,
  input  fpc_pkg::fpc_word_t  a,
  input  fpc_pkg::fpc_word_t  b,
  input  fpc_pkg::fpc_tag_t   tag,
  output logic                busy,
  output logic                done,
  output fpc_pkg::fpc_word_t  result,
  output fpc_pkg::fpc_flags_t flags,
  output fpc_pkg::fpc_tag_t   res_tag
);
  import fpc_pkg::*;

  fpc_lane_state_t state;
  fpc_op_t         op_q;      // Op for the CMP stage
  fpc_op_t         op_pk;     // Delayed copy for PACK
  fpc_tag_t        tag_q;
  fpc_half_t       a_h [2];   // Index 0 is the low half
  fpc_half_t       b_h [2];

  // Unpack stage
  logic [1:0] nan_a_d, nan_b_d, zero_a_d, zero_b_d;
  logic [1:0] nan_a_q, nan_b_q, zero_a_q, zero_b_q;
  fpc_half_t  key_a_d [2];
  fpc_half_t  key_b_d [2];
  fpc_half_t  key_a_q [2];
  fpc_half_t  key_b_q [2];

  // Compare stage
  fpc_half_t  res_d [2];
  fpc_half_t  res_q [2];
  fpc_flags_t flg_d [2];
  fpc_flags_t flg_q [2];

  // ====================================================================
  // Classification and order key
  // ====================================================================
  always_comb begin
    for (int h = 0; h < 2; h++) begin
      nan_a_d[h]  = (a_h[h][30:23] == EXP_ONES) && (a_h[h][22:0] != '0);
      nan_b_d[h]  = (b_h[h][30:23] == EXP_ONES) && (b_h[h][22:0] != '0);
      zero_a_d[h] = a_h[h][30:0] == '0;
      zero_b_d[h] = b_h[h][30:0] == '0;
      // Negative values invert so unsigned order matches numeric order
      key_a_d[h] = a_h[h][31] ? ~a_h[h] : {1'b1, a_h[h][30:0]};
      key_b_d[h] = b_h[h][31] ? ~b_h[h] : {1'b1, b_h[h][30:0]};
    end
  end

  // ====================================================================
  // Per-half compare and sign operations
  // ====================================================================
  always_comb begin
    logic      unord, eq, lt, gt;
    fpc_half_t mn, mx;
    for (int h = 0; h < 2; h++) begin
      unord = nan_a_q[h] | nan_b_q[h];
      eq    = ~unord & ((key_a_q[h] == key_b_q[h]) | (zero_a_q[h] & zero_b_q[h]));
      lt    = ~unord & ~eq & (key_a_q[h] < key_b_q[h]);
      gt    = ~unord & ~eq & ~lt;

      if (nan_a_q[h] && nan_b_q[h]) begin
        mn = CANON_NAN;
        mx = CANON_NAN;
      end else if (nan_a_q[h]) begin
        mn = b_h[h];                                      // Other input wins
        mx = b_h[h];
      end else if (nan_b_q[h]) begin
        mn = a_h[h];
        mx = a_h[h];
      end else begin
        mn = (key_a_q[h] < key_b_q[h]) ? a_h[h] : b_h[h]; // -0 sorts below +0
        mx = (key_a_q[h] < key_b_q[h]) ? b_h[h] : a_h[h];
      end

      flg_d[h] = '0;
      if (op_q inside {OP_CMP_LO, OP_CMP_HI, OP_MIN, OP_MAX}) begin
        flg_d[h][FLAG_LT]  = lt;
        flg_d[h][FLAG_EQ]  = eq;
        flg_d[h][FLAG_GT]  = gt;
        flg_d[h][FLAG_UN]  = unord;
        flg_d[h][FLAG_INV] = unord;
      end

      case (op_q)
        OP_MIN:  res_d[h] = mn;
        OP_MAX:  res_d[h] = mx;
        OP_ABS:  res_d[h] = {1'b0, a_h[h][30:0]};
        OP_NEG:  res_d[h] = {~a_h[h][31], a_h[h][30:0]};
        OP_SGNJ: res_d[h] = {b_h[h][31], a_h[h][30:0]};
        default: res_d[h] = '0;                           // Compare ops
      endcase
    end
  end

  // ====================================================================
  // Control and stage registers
  // ====================================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:   if (start) state <= ST_UNPACK;
        ST_UNPACK: state <= ST_CMP;
        ST_CMP:    state <= ST_PACK;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      a_h[0] <= a[HALF_W-1:0];
      a_h[1] <= a[WORD_W-1:HALF_W];
      b_h[0] <= b[HALF_W-1:0];
      b_h[1] <= b[WORD_W-1:HALF_W];
      op_q   <= op;
      tag_q  <= tag;
    end
    if (state == ST_UNPACK) begin
      nan_a_q  <= nan_a_d;
      nan_b_q  <= nan_b_d;
      zero_a_q <= zero_a_d;
      zero_b_q <= zero_b_d;
      key_a_q  <= key_a_d;
      key_b_q  <= key_b_d;
    end
    if (state == ST_CMP) begin
      res_q <= res_d;
      flg_q <= flg_d;
      op_pk <= op_q;
    end
  end

  assign busy    = state != ST_IDLE;
  assign done    = state == ST_PACK;
  assign result  = {res_q[1], res_q[0]};
  assign flags   = (op_pk == OP_CMP_HI) ? flg_q[1] : flg_q[0];
  assign res_tag = tag_q;

endmodule

/* rtl/fpc_dispatch.sv */
`timescale 1ns/1ns

module fpc_dispatch (
  input  logic                           clk,
  input  logic                           arst_n,
  input  logic                           in_valid,
  input  fpc_pkg::fpc_op_t               in_op,
  input  fpc_pkg::fpc_word_t             in_a,
  input  fpc_pkg::fpc_word_t             in_b,
  input  fpc_pkg::fpc_tag_t              in_tag,
  output logic                           in_ready,
  input  logic [fpc_pkg::NUM_LANES-1:0]  lane_busy,
  output logic [fpc_pkg::NUM_LANES-1:0]  lane_start,
  output fpc_pkg::fpc_op_t               lane_op,
  output fpc_pkg::fpc_word_t             lane_a,
  output fpc_pkg::fpc_word_t             lane_b,
  output fpc_pkg::fpc_tag_t              lane_tag
);
  import fpc_pkg::*;

  logic [NUM_LANES-1:0] idle;
  logic                 accept;
  lane_sel_t            ptr;     // Round-robin start point
  lane_sel_t            pick;

  // A lane being started this cycle is not busy yet but is taken
  assign idle     = ~lane_busy & ~lane_start;
  assign in_ready = |idle;
  assign accept   = in_valid & in_ready;

  // ====================================================================
  // First idle lane at or after the pointer
  // ====================================================================
  always_comb begin
    int   idx;
    logic found;
    found = 1'b0;
    pick  = ptr;
    for (int k = 0; k < NUM_LANES; k++) begin
      idx = (int'(ptr) + k) % NUM_LANES;
      if (!found && idle[idx]) begin
        found = 1'b1;
        pick  = lane_sel_t'(idx);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr        <= '0;
      lane_start <= '0;
    end else begin
      lane_start <= '0;
      if (accept) begin
        lane_start[pick] <= 1'b1;                        // One-cycle pulse
        ptr <= (pick == lane_sel_t'(NUM_LANES - 1)) ? '0 : pick + 1'b1;
      end
    end
  end

  // Shared payload, held until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      lane_op  <= in_op;
      lane_a   <= in_a;
      lane_b   <= in_b;
      lane_tag <= in_tag;
    end
  end

endmodule

/* rtl/fpc_pkg.sv */
package fpc_pkg;

  // ====================================================================
  // Widths and lane count
  // ====================================================================
  localparam int HALF_W    = 32;
  localparam int WORD_W    = 2 * HALF_W;
  localparam int TAG_W     = 4;
  localparam int NUM_LANES = 3;

  typedef logic [WORD_W-1:0] fpc_word_t;  // Low single in [31:0], high above
  typedef logic [HALF_W-1:0] fpc_half_t;
  typedef logic [TAG_W-1:0]  fpc_tag_t;
  typedef logic [4:0]        fpc_flags_t; // {lt, eq, gt, unord, inv}
  typedef logic [1:0]        lane_sel_t;

  // ====================================================================
  // Flag bit positions
  // ====================================================================
  localparam int FLAG_LT  = 4;
  localparam int FLAG_EQ  = 3;
  localparam int FLAG_GT  = 2;
  localparam int FLAG_UN  = 1;
  localparam int FLAG_INV = 0;

  // Single-precision constants
  localparam fpc_half_t  CANON_NAN = 32'h7FC0_0000;
  localparam logic [7:0] EXP_ONES  = 8'hFF;

  // ====================================================================
  // Encodings
  // ====================================================================
  typedef enum logic [2:0] {
    OP_CMP_LO = 3'd0,  // Flags from low half
    OP_CMP_HI = 3'd1,  // Flags from high half
    OP_MIN    = 3'd2,
    OP_MAX    = 3'd3,
    OP_ABS    = 3'd4,
    OP_NEG    = 3'd5,
    OP_SGNJ   = 3'd6   // Magnitude of a, sign of b
  } fpc_op_t;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_UNPACK = 2'd1,
    ST_CMP    = 2'd2,
    ST_PACK   = 2'd3
  } fpc_lane_state_t;

endpackage
